/* src/rv_core_params.svh */
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// data path width
`define XLEN 32

// register file geometry
`define REG_ADDR_BITS 5
`define NUM_REGS 32

// word address into the external memory, 4 KB
`define MEM_ADDR_BITS 10

`endif

/* src/rv_isa_pkg.sv */
`include "rv_core_params.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0]          word_t;
    typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [`XLEN-1:0]          pc_t;
    typedef logic [`MEM_ADDR_BITS-1:0] mem_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_STORE  = 7'b0100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

endpackage

/* src/rv_core_pkg.sv */
package rv_core_pkg;

    import rv_isa_pkg::*;

    // one instruction every four cycles
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_CAPTURE,
        ST_DECODE,
        ST_EXECUTE,
        ST_HALT
    } ctrl_state_e;

    // decoded controls, registered at the end of DECODE
    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        logic      write_rd;
        reg_addr_t rd;
        logic      is_lui;
        logic      is_jal;
        logic      is_branch;
        logic      branch_ne;
        logic      is_store;
        logic      halt;
        word_t     imm;
    } decode_ctl_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

    typedef struct packed {
        logic taken;
        pc_t  target;
    } redirect_t;

    typedef struct packed {
        logic  valid;
        pc_t   addr;
        word_t data;
    } store_req_t;

endpackage

/* src/rv_controller.sv */
`timescale 1ns/1ps

module rv_controller
    import rv_core_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        start_i,
    input  logic        halt_i,
    output ctrl_state_e state_o,
    output logic        paused_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // --------------------
    // phase sequencing
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE, ST_HALT: begin
                if (start_i) begin
                    state_d = ST_FETCH;
                end
            end
            ST_FETCH:   state_d = ST_CAPTURE;
            ST_CAPTURE: state_d = ST_DECODE;
            // unsupported or SYSTEM opcode stops before execute
            ST_DECODE:  state_d = halt_i ? ST_HALT : ST_EXECUTE;
            ST_EXECUTE: state_d = ST_FETCH;
            default:    state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

    // debugger may own the register file only here
    assign paused_o = (state_q == ST_IDLE) || (state_q == ST_HALT);

    // --------------------
    // checks
    a_state_legal: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        state_q inside {ST_IDLE, ST_FETCH, ST_CAPTURE, ST_DECODE, ST_EXECUTE, ST_HALT}
    ) else $error("controller state out of range: %0d", state_q);

endmodule

/* src/rv_bus_unit.sv */
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_bus_unit
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  ctrl_state_e        state_i,
    input  logic               start_i,
    input  pc_t                start_address_i,
    input  redirect_t          redirect_i,
    input  store_req_t         store_i,
    input  word_t              mem_read_data_i,
    output word_t              ir_o,
    output pc_t                pc_o,
    output mem_addr_t          mem_addr_o,
    output logic [`XLEN/8-1:0] mem_write_en_o,
    output word_t              mem_write_data_o
);

    pc_t   pc_q;
    word_t ir_q;
    logic  stopped;

    assign stopped = (state_i == ST_IDLE) || (state_i == ST_HALT);

    // pc moves only at the end of execute
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (start_i && stopped) begin
            pc_q <= start_address_i;
        end else if (state_i == ST_EXECUTE) begin
            pc_q <= redirect_i.taken ? redirect_i.target : pc_q + pc_t'(4);
        end
    end

    // read data is for the address of the previous cycle
    always_ff @(posedge clk_i) begin
        if (state_i == ST_CAPTURE) begin
            ir_q <= mem_read_data_i;
        end
    end

    // store takes the port over for its one cycle
    assign mem_addr_o = store_i.valid ? store_i.addr[`MEM_ADDR_BITS+1:2]
                                      : pc_q[`MEM_ADDR_BITS+1:2];
    assign mem_write_en_o   = {(`XLEN/8){store_i.valid}};
    assign mem_write_data_o = store_i.data;

    assign ir_o = ir_q;
    assign pc_o = pc_q;

    a_store_in_execute: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (mem_write_en_o != '0) |-> (state_i == ST_EXECUTE)
    ) else $error("memory write outside EXECUTE");

endmodule

/* src/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  ctrl_state_e state_i,
    input  word_t       ir_i,
    output reg_addr_t   rs1_addr_o,
    output reg_addr_t   rs2_addr_o,
    output logic        halt_o,
    output decode_ctl_t ctl_o
);

    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       imm_u;
    word_t       imm_j;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        supported;
    decode_ctl_t ctl_d;
    decode_ctl_t ctl_q;

    // only add, xor, or and and of the funct3 space
    function automatic logic alu_funct3_ok(input logic [2:0] f3);
        return f3 inside {3'b000, 3'b100, 3'b110, 3'b111};
    endfunction

    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3);
        case (f3)
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign funct3     = ir_i[14:12];
    assign funct7     = ir_i[31:25];
    assign rs1_addr_o = ir_i[19:15];
    assign rs2_addr_o = ir_i[24:20];

    // --------------------
    // immediate formats
    assign imm_i = {{20{ir_i[31]}}, ir_i[31:20]};
    assign imm_s = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_b = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
    assign imm_u = {ir_i[31:12], 12'b0};
    assign imm_j = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

    always_comb begin
        ctl_d        = '0;
        ctl_d.alu_op = alu_from_funct3(funct3);
        ctl_d.rd     = ir_i[11:7];
        supported    = 1'b1;
        case (opcode_e'(ir_i[6:0]))
            OPC_OP_IMM: begin
                supported      = alu_funct3_ok(funct3);
                ctl_d.use_imm  = 1'b1;
                ctl_d.write_rd = 1'b1;
                ctl_d.imm      = imm_i;
            end
            OPC_OP: begin
                // sub is the one alternate funct7 kept
                if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    ctl_d.alu_op = ALU_SUB;
                end else begin
                    supported = (funct7 == 7'b0000000) && alu_funct3_ok(funct3);
                end
                ctl_d.write_rd = 1'b1;
            end
            OPC_LUI: begin
                ctl_d.write_rd = 1'b1;
                ctl_d.is_lui   = 1'b1;
                ctl_d.imm      = imm_u;
            end
            OPC_JAL: begin
                ctl_d.write_rd = 1'b1;
                ctl_d.is_jal   = 1'b1;
                ctl_d.imm      = imm_j;
            end
            OPC_BRANCH: begin
                // beq and bne only
                supported       = (funct3[2:1] == 2'b00);
                ctl_d.is_branch = 1'b1;
                ctl_d.branch_ne = funct3[0];
                ctl_d.imm       = imm_b;
            end
            OPC_STORE: begin
                supported      = (funct3 == 3'b010);
                ctl_d.is_store = 1'b1;
                ctl_d.use_imm  = 1'b1;
                ctl_d.alu_op   = ALU_ADD;
                ctl_d.imm      = imm_s;
            end
            OPC_SYSTEM: supported = 1'b0;
            default:    supported = 1'b0;
        endcase
        ctl_d.halt = !supported;
    end

    assign halt_o = ctl_d.halt;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctl_q <= '0;
        end else if (state_i == ST_DECODE) begin
            ctl_q <= ctl_d;
        end
    end

    assign ctl_o = ctl_q;

endmodule

/* src/rv_reg_file.sv */
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_reg_file
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       paused_i,
    input  reg_addr_t  rs1_addr_i,
    input  reg_addr_t  rs2_addr_i,
    input  reg_write_t wb_i,
    input  reg_addr_t  ocd_reg_read_addr_i,
    input  logic       ocd_reg_we_i,
    input  reg_addr_t  ocd_reg_write_addr_i,
    input  word_t      ocd_reg_write_data_i,
    output word_t      rs1_data_o,
    output word_t      rs2_data_o,
    output word_t      ocd_reg_data_o
);

    word_t     regs [`NUM_REGS];
    reg_addr_t rd2_addr;
    reg_addr_t wr_addr;
    word_t     wr_data;
    logic      wr_en;
    word_t     rs1_q;
    word_t     rs2_q;

    // debugger owns port 2 and the write port while paused
    assign rd2_addr = paused_i ? ocd_reg_read_addr_i  : rs2_addr_i;
    assign wr_en    = paused_i ? ocd_reg_we_i         : wb_i.we;
    assign wr_addr  = paused_i ? ocd_reg_write_addr_i : wb_i.addr;
    assign wr_data  = paused_i ? ocd_reg_write_data_i : wb_i.data;

    // x0 cleared by reset and never stored
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            regs[0] <= '0;
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // one cycle read latency on both ports
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rs1_q <= '0;
            rs2_q <= '0;
        end else begin
            rs1_q <= regs[rs1_addr_i];
            rs2_q <= regs[rd2_addr];
        end
    end

    assign rs1_data_o     = rs1_q;
    assign rs2_data_o     = rs2_q;
    assign ocd_reg_data_o = rs2_q;

    a_x0_stays_zero: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        regs[0] == '0
    ) else $error("write to x0 took effect");

endmodule

/* src/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  ctrl_state_e state_i,
    input  pc_t         pc_i,
    input  decode_ctl_t ctl_i,
    input  word_t       rs1_i,
    input  word_t       rs2_i,
    output reg_write_t  wb_o,
    output redirect_t   redirect_o,
    output store_req_t  store_o
);

    logic  active;
    word_t operand_b;
    word_t alu_res;
    word_t wb_data;
    logic  branch_taken;

    assign active    = (state_i == ST_EXECUTE) && !ctl_i.halt;
    assign operand_b = ctl_i.use_imm ? ctl_i.imm : rs2_i;

    // --------------------
    // alu
    always_comb begin
        case (ctl_i.alu_op)
            ALU_SUB: alu_res = rs1_i - operand_b;
            ALU_AND: alu_res = rs1_i & operand_b;
            ALU_OR:  alu_res = rs1_i | operand_b;
            ALU_XOR: alu_res = rs1_i ^ operand_b;
            default: alu_res = rs1_i + operand_b;
        endcase
    end

    // result select for writeback
    always_comb begin
        if (ctl_i.is_lui) begin
            wb_data = ctl_i.imm;
        end else if (ctl_i.is_jal) begin
            wb_data = pc_i + pc_t'(4);
        end else begin
            wb_data = alu_res;
        end
    end

    // bne inverts the equality test
    assign branch_taken = ctl_i.is_branch && ((rs1_i == rs2_i) ^ ctl_i.branch_ne);

    assign wb_o = '{
        we:   active && ctl_i.write_rd,
        addr: ctl_i.rd,
        data: wb_data
    };

    // jal and branch both target pc plus immediate
    assign redirect_o = '{
        taken:  active && (ctl_i.is_jal || branch_taken),
        target: pc_i + ctl_i.imm
    };

    // store address comes out of the adder
    assign store_o = '{
        valid: active && ctl_i.is_store,
        addr:  alu_res,
        data:  rs2_i
    };

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_core
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               start_i,
    input  pc_t                start_address_i,
    input  reg_addr_t          ocd_reg_read_addr_i,
    input  logic               ocd_reg_we_i,
    input  reg_addr_t          ocd_reg_write_addr_i,
    input  word_t              ocd_reg_write_data_i,
    output word_t              ocd_reg_data_o,
    output mem_addr_t          mem_addr_o,
    output logic [`XLEN/8-1:0] mem_write_en_o,
    output word_t              mem_write_data_o,
    input  word_t              mem_read_data_i,
    output pc_t                peek_pc_o,
    output word_t              peek_ir_o,
    output logic               processor_paused_o
);

    ctrl_state_e state;
    logic        paused;
    logic        halt;
    word_t       ir;
    pc_t         pc;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    word_t       rs1_data;
    word_t       rs2_data;
    decode_ctl_t ctl;
    reg_write_t  wb;
    redirect_t   redirect;
    store_req_t  store;

    // --------------------
    // control
    rv_controller u_controller (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .start_i  (start_i),
        .halt_i   (halt),
        .state_o  (state),
        .paused_o (paused)
    );

    // --------------------
    // datapath
    rv_bus_unit u_bus_unit (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .state_i          (state),
        .start_i          (start_i),
        .start_address_i  (start_address_i),
        .redirect_i       (redirect),
        .store_i          (store),
        .mem_read_data_i  (mem_read_data_i),
        .ir_o             (ir),
        .pc_o             (pc),
        .mem_addr_o       (mem_addr_o),
        .mem_write_en_o   (mem_write_en_o),
        .mem_write_data_o (mem_write_data_o)
    );

    rv_decode u_decode (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .state_i    (state),
        .ir_i       (ir),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .halt_o     (halt),
        .ctl_o      (ctl)
    );

    rv_reg_file u_reg_file (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .paused_i             (paused),
        .rs1_addr_i           (rs1_addr),
        .rs2_addr_i           (rs2_addr),
        .wb_i                 (wb),
        .ocd_reg_read_addr_i  (ocd_reg_read_addr_i),
        .ocd_reg_we_i         (ocd_reg_we_i),
        .ocd_reg_write_addr_i (ocd_reg_write_addr_i),
        .ocd_reg_write_data_i (ocd_reg_write_data_i),
        .rs1_data_o           (rs1_data),
        .rs2_data_o           (rs2_data),
        .ocd_reg_data_o       (ocd_reg_data_o)
    );

    rv_execute u_execute (
        .state_i    (state),
        .pc_i       (pc),
        .ctl_i      (ctl),
        .rs1_i      (rs1_data),
        .rs2_i      (rs2_data),
        .wb_o       (wb),
        .redirect_o (redirect),
        .store_o    (store)
    );

    // debug visibility
    assign peek_pc_o          = pc;
    assign peek_ir_o          = ir;
    assign processor_paused_o = paused;

endmodule

/* tb/rv_core_tb.sv */
`timescale 1ns/1ps

`include "rv_core_params.svh"

module rv_core_tb
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
();

    // about 150 instructions at four cycles each plus debugger traffic, with margin
    localparam int    TIMEOUT_CYCLES = 3000;
    localparam word_t ECALL          = 32'h0000_0073;

    logic               clk_i;
    logic               rst_n_i;
    logic               start_i;
    pc_t                start_address_i;
    reg_addr_t          ocd_reg_read_addr_i;
    logic               ocd_reg_we_i;
    reg_addr_t          ocd_reg_write_addr_i;
    word_t              ocd_reg_write_data_i;
    word_t              ocd_reg_data_o;
    mem_addr_t          mem_addr_o;
    logic [`XLEN/8-1:0] mem_write_en_o;
    word_t              mem_write_data_o;
    word_t              mem_read_data_i;
    pc_t                peek_pc_o;
    word_t              peek_ir_o;
    logic               processor_paused_o;

    word_t              mem [2**`MEM_ADDR_BITS];
    word_t              prog [$];
    mem_addr_t          st_addr_q [$];
    word_t              st_data_q [$];
    logic [`XLEN/8-1:0] st_en_q [$];
    string              test_name;
    int                 cycles;

    rv_core uut (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .start_i              (start_i),
        .start_address_i      (start_address_i),
        .ocd_reg_read_addr_i  (ocd_reg_read_addr_i),
        .ocd_reg_we_i         (ocd_reg_we_i),
        .ocd_reg_write_addr_i (ocd_reg_write_addr_i),
        .ocd_reg_write_data_i (ocd_reg_write_data_i),
        .ocd_reg_data_o       (ocd_reg_data_o),
        .mem_addr_o           (mem_addr_o),
        .mem_write_en_o       (mem_write_en_o),
        .mem_write_data_o     (mem_write_data_o),
        .mem_read_data_i      (mem_read_data_i),
        .peek_pc_o            (peek_pc_o),
        .peek_ir_o            (peek_ir_o),
        .processor_paused_o   (processor_paused_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // --------------------
    // synchronous memory, one cycle read latency
    always @(posedge clk_i) begin
        mem_read_data_i <= mem[mem_addr_o];
        if (mem_write_en_o != '0) begin
            mem[mem_addr_o] <= mem_write_data_o;
            st_addr_q.push_back(mem_addr_o);
            st_data_q.push_back(mem_write_data_o);
            st_en_q.push_back(mem_write_en_o);
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles in %s", cycles, test_name);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // instruction encoders
    function automatic word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic word_t imm_op(input logic [2:0] f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t upper_imm(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic word_t jump_link(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t cond_branch(input logic [2:0] f3, input reg_addr_t rs1,
                                          input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t store_word(input reg_addr_t rs2, input reg_addr_t rs1,
                                         input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    // --------------------
    // checks
    task automatic check_word(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_pc(input string what, input pc_t expected, input pc_t actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic check_addr(input string what, input mem_addr_t expected,
                              input mem_addr_t actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "address mismatch");
        end
    endtask

    // --------------------
    // bus helpers
    task automatic load_program(input pc_t base);
        mem_addr_t wa;
        wa = base[`MEM_ADDR_BITS+1:2];
        foreach (prog[i]) begin
            mem[wa] = prog[i];
            wa = wa + 1'b1;
        end
    endtask

    task automatic run_program(input pc_t base);
        load_program(base);
        @(negedge clk_i);
        start_address_i = base;
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        while (!processor_paused_o) begin
            @(negedge clk_i);
        end
    endtask

    task automatic read_reg(input reg_addr_t r, output word_t v);
        @(negedge clk_i);
        ocd_reg_read_addr_i = r;
        @(negedge clk_i);
        v = ocd_reg_data_o;
    endtask

    task automatic write_reg(input reg_addr_t r, input word_t v);
        @(negedge clk_i);
        ocd_reg_we_i = 1'b1;
        ocd_reg_write_addr_i = r;
        ocd_reg_write_data_i = v;
        @(negedge clk_i);
        ocd_reg_we_i = 1'b0;
    endtask

    task automatic expect_reg(input reg_addr_t r, input word_t expected);
        word_t got;
        read_reg(r, got);
        check_word($sformatf("x%0d", r), expected, got);
    endtask

    // --------------------
    // directed tests
    task automatic reset_state();
        test_name = "reset_state";
        check_word("paused", 32'd1, {31'h0, processor_paused_o});
        check_word("write enables", 32'd0, {28'h0, mem_write_en_o});
        check_pc("pc", 32'h0, peek_pc_o);
    endtask

    task automatic alu_program();
        word_t a;
        word_t b;
        test_name = "alu_program";
        a = sext12(12'h123);
        b = sext12(12'hffb);
        prog.delete();
        prog.push_back(imm_op(3'b000, 5'd1, 5'd0, 12'h123));
        prog.push_back(imm_op(3'b000, 5'd2, 5'd0, 12'hffb));
        prog.push_back(reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        prog.push_back(reg_op(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
        prog.push_back(reg_op(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
        prog.push_back(reg_op(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
        prog.push_back(reg_op(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
        prog.push_back(upper_imm(5'd8, 20'habcde));
        prog.push_back(imm_op(3'b111, 5'd9, 5'd2, 12'h0f0));
        prog.push_back(imm_op(3'b110, 5'd10, 5'd1, 12'h700));
        prog.push_back(imm_op(3'b100, 5'd11, 5'd1, 12'hfff));
        prog.push_back(ECALL);
        run_program(32'h0);
        check_pc("halt pc", 32'h2c, peek_pc_o);
        expect_reg(5'd1, a);
        expect_reg(5'd2, b);
        expect_reg(5'd3, a + b);
        expect_reg(5'd4, a - b);
        expect_reg(5'd5, a & b);
        expect_reg(5'd6, a | b);
        expect_reg(5'd7, a ^ b);
        expect_reg(5'd8, {20'habcde, 12'h000});
        expect_reg(5'd9, b & sext12(12'h0f0));
        expect_reg(5'd10, a | sext12(12'h700));
        expect_reg(5'd11, a ^ sext12(12'hfff));
    endtask

    task automatic store_program();
        pc_t   ea0;
        pc_t   ea1;
        word_t d0;
        word_t d1;
        test_name = "store_program";
        ea0 = sext12(12'h200) + sext12(12'h008);
        ea1 = sext12(12'h200) + sext12(12'hffc);
        d1 = {20'h12345, 12'h000};
        d0 = sext12(12'h5a5) ^ d1;
        prog.delete();
        prog.push_back(imm_op(3'b000, 5'd1, 5'd0, 12'h200));
        prog.push_back(imm_op(3'b000, 5'd2, 5'd0, 12'h5a5));
        prog.push_back(upper_imm(5'd3, 20'h12345));
        prog.push_back(reg_op(7'h00, 3'b100, 5'd2, 5'd2, 5'd3));
        prog.push_back(store_word(5'd2, 5'd1, 12'h008));
        prog.push_back(store_word(5'd3, 5'd1, 12'hffc));
        prog.push_back(ECALL);
        st_addr_q.delete();
        st_data_q.delete();
        st_en_q.delete();
        run_program(32'h100);
        check_word("store count", 32'd2, word_t'(st_addr_q.size()));
        check_addr("store 0 addr", ea0[`MEM_ADDR_BITS+1:2], st_addr_q[0]);
        check_word("store 0 enables", 32'hf, {28'h0, st_en_q[0]});
        check_word("store 0 data", d0, st_data_q[0]);
        check_addr("store 1 addr", ea1[`MEM_ADDR_BITS+1:2], st_addr_q[1]);
        check_word("store 1 enables", 32'hf, {28'h0, st_en_q[1]});
        check_word("store 1 data", d1, st_data_q[1]);
        check_word("memory word", d0, mem[ea0[`MEM_ADDR_BITS+1:2]]);
    endtask

    task automatic control_flow();
        test_name = "control_flow";
        write_reg(5'd3, 32'h0);
        write_reg(5'd6, 32'h0);
        prog.delete();
        prog.push_back(imm_op(3'b000, 5'd1, 5'd0, 12'h007));
        prog.push_back(imm_op(3'b000, 5'd2, 5'd0, 12'h007));
        // taken beq skips one word, then bne falls through
        prog.push_back(cond_branch(3'b000, 5'd1, 5'd2, 13'd8));
        prog.push_back(imm_op(3'b000, 5'd3, 5'd0, 12'h001));
        prog.push_back(cond_branch(3'b001, 5'd1, 5'd2, 13'd8));
        prog.push_back(imm_op(3'b000, 5'd4, 5'd0, 12'h002));
        prog.push_back(jump_link(5'd5, 21'd8));
        prog.push_back(imm_op(3'b000, 5'd6, 5'd0, 12'h003));
        prog.push_back(ECALL);
        run_program(32'h200);
        check_pc("halt pc", 32'h220, peek_pc_o);
        check_word("halt ir", ECALL, peek_ir_o);
        expect_reg(5'd3, 32'h0);
        expect_reg(5'd4, 32'h2);
        expect_reg(5'd5, 32'h21c);
        expect_reg(5'd6, 32'h0);
    endtask

    task automatic debugger_regs();
        word_t v;
        test_name = "debugger_regs";
        v = 32'hcafe_0123;
        write_reg(5'd12, v);
        write_reg(5'd0, 32'hffff_ffff);
        expect_reg(5'd0, 32'h0);
        prog.delete();
        prog.push_back(imm_op(3'b000, 5'd13, 5'd12, 12'h011));
        prog.push_back(reg_op(7'h00, 3'b000, 5'd15, 5'd0, 5'd12));
        prog.push_back(ECALL);
        run_program(32'h300);
        expect_reg(5'd13, v + sext12(12'h011));
        expect_reg(5'd15, v);
        expect_reg(5'd0, 32'h0);
    endtask

    task automatic random_chains();
        word_t       model;
        logic [11:0] imm;
        logic [2:0]  f3;
        test_name = "random_chains";
        for (int n = 0; n < 20; n++) begin
            prog.delete();
            imm = 12'($urandom);
            model = sext12(imm);
            prog.push_back(imm_op(3'b000, 5'd1, 5'd0, imm));
            for (int k = 0; k < 4; k++) begin
                imm = 12'($urandom);
                f3 = ($urandom & 1) ? 3'b100 : 3'b000;
                prog.push_back(imm_op(f3, 5'd1, 5'd1, imm));
                model = (f3 == 3'b100) ? (model ^ sext12(imm)) : (model + sext12(imm));
            end
            prog.push_back(ECALL);
            run_program(32'h400);
            check_pc("halt pc", 32'h414, peek_pc_o);
            expect_reg(5'd1, model);
        end
    endtask

    initial begin
        rst_n_i = 1'b0;
        start_i = 1'b0;
        start_address_i = '0;
        ocd_reg_read_addr_i = '0;
        ocd_reg_we_i = 1'b0;
        ocd_reg_write_addr_i = '0;
        ocd_reg_write_data_i = '0;
        mem_read_data_i = '0;
        cycles = 0;
        test_name = "setup";
        void'($urandom(32'h9204));
        // unused words decode as SYSTEM with the address in the top bits
        for (int i = 0; i < 2**`MEM_ADDR_BITS; i++) begin
            mem[i[`MEM_ADDR_BITS-1:0]] = {i[`MEM_ADDR_BITS-1:0], 15'h0, 7'b1110011};
        end
        repeat (3) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        reset_state();
        alu_program();
        store_program();
        control_flow();
        debugger_regs();
        random_chains();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* all.f */
+incdir+src
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/rv_controller.sv
src/rv_bus_unit.sv
src/rv_decode.sv
src/rv_reg_file.sv
src/rv_execute.sv
src/rv_core.sv
tb/rv_core_tb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, and judge the run by its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module rv_core_tb -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation failed" sim.log && { echo "run FAILED"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "run FAILED"; exit 1; }
echo "run passed"
